// File: source/fastCyclePkg.sv
// ------------------------------
// Fast cycle shared definitions
// Memory map, table sizes, word fields and the slot enum
// ------------------------------

package fastCyclePkg;

	// Fast VRAM geometry
	localparam int vramAddrW = 11;
	localparam int vramDataW = 16;

	// Table sizes
	localparam int numSprites = 96;
	localparam int activeCap = 48;

	// Sprite number width, and active list entry index width
	localparam int idxW = 7;
	// Also sets the bank stride of 64 words
	localparam int cntW = 6;

	// Region bases
	localparam logic [vramAddrW-1:0] shrinkBase = 11'h000;
	localparam logic [vramAddrW-1:0] yTableBase = 11'h200;
	localparam logic [vramAddrW-1:0] xTableBase = 11'h400;
	localparam logic [vramAddrW-1:0] activeBase = 11'h600;

	// Y word: Y in 15..7, chain in 6, size in 5..0
	localparam int yLsb = 7;
	localparam int chainBit = 6;
	localparam int sizeW = 6;

	// X word: X in 15..7, horizontal shrink in 3..0
	localparam int xLsb = 7;
	localparam int hShrinkW = 4;

	// Raster line number
	localparam int lineW = 9;

	// Fast cycle slots, in rotation order
	typedef enum logic [1:0] {
		slotCpu,
		slotParse,
		slotActive,
		slotRender
	} slotT;

endpackage

// File: source/fastVram.sv
// ------------------------------
// Fast VRAM
// Single-port 2048 x 16 synchronous RAM, read-first
// ------------------------------

`timescale 1ns/1ps

module fastVram (
	input  logic                                clk24M,
	input  logic [fastCyclePkg::vramAddrW-1:0] addr,
	input  logic [fastCyclePkg::vramDataW-1:0] wrData,
	input  logic                                wrEn,
	output logic [fastCyclePkg::vramDataW-1:0] rdData
);

	// Upper and lower byte chips as one word array
	logic [fastCyclePkg::vramDataW-1:0] mem [0:2**fastCyclePkg::vramAddrW-1];

	always_ff @(posedge clk24M) begin
		if (wrEn) begin
			mem[addr] <= wrData;
		end
		// Old word comes back on a write cycle
		rdData <= mem[addr];
	end

endmodule

// File: source/slotSequencer.sv
// ------------------------------
// Slot sequencer
// Two-bit fast cycle counter, flags the last slot of a round
// ------------------------------

`timescale 1ns/1ps

module slotSequencer (
	input  logic               clk24M,
	input  logic               rstN,
	output fastCyclePkg::slotT slot,
	output logic               roundEnd
);

	// Render slot closes the round
	assign roundEnd = (slot == fastCyclePkg::slotRender);

	always_ff @(posedge clk24M) begin
		if (!rstN) begin
			slot <= fastCyclePkg::slotCpu;
		end else if (roundEnd) begin
			slot <= fastCyclePkg::slotCpu;
		end else begin
			slot <= fastCyclePkg::slotT'(slot + 2'd1);
		end
	end

endmodule

// File: source/vramArbiter.sv
// ------------------------------
// VRAM arbiter
// Per-slot address and data select, CPU request latch
// and CPU read register
// ------------------------------

`timescale 1ns/1ps

module vramArbiter (
	input  logic                                clk24M,
	input  logic                                rstN,
	input  fastCyclePkg::slotT                  slot,
	input  logic [fastCyclePkg::vramAddrW-1:0] cpuAddr,
	input  logic [fastCyclePkg::vramDataW-1:0] cpuWrData,
	input  logic                                cpuWrReq,
	input  logic                                cpuRdReq,
	output logic [fastCyclePkg::vramDataW-1:0] cpuRdData,
	output logic                                cpuRdValid,
	output logic                                cpuBusy,
	input  logic [fastCyclePkg::vramAddrW-1:0] parseAddr,
	input  logic                                parseWrEn,
	input  logic [fastCyclePkg::vramAddrW-1:0] parseWrAddr,
	input  logic [fastCyclePkg::vramDataW-1:0] parseWrData,
	input  logic [fastCyclePkg::vramAddrW-1:0] actAddr,
	input  logic [fastCyclePkg::vramAddrW-1:0] attrAddr,
	output logic [fastCyclePkg::vramAddrW-1:0] vramAddr,
	output logic [fastCyclePkg::vramDataW-1:0] vramWrData,
	output logic                                vramWrEn,
	input  logic [fastCyclePkg::vramDataW-1:0] vramRdData
);

	logic                                pendWr;
	logic [fastCyclePkg::vramAddrW-1:0] pendAddr;
	logic [fastCyclePkg::vramDataW-1:0] pendData;
	logic                                cpuGrant;
	logic                                cpuTake;
	logic                                rdCapture;
	logic [fastCyclePkg::vramDataW-1:0] rdHold;

	// Pending access gets the next CPU slot
	assign cpuGrant = (slot == fastCyclePkg::slotCpu) && cpuBusy;
	assign cpuTake = !cpuBusy && (cpuWrReq || cpuRdReq);

	always_ff @(posedge clk24M) begin
		if (!rstN) begin
			cpuBusy <= 1'b0;
			rdCapture <= 1'b0;
		end else begin
			rdCapture <= cpuGrant && !pendWr;
			if (cpuGrant) begin
				cpuBusy <= 1'b0;
			end else if (cpuTake) begin
				cpuBusy <= 1'b1;
			end
		end
	end

	// Request payload, write wins over read
	always_ff @(posedge clk24M) begin
		if (cpuTake) begin
			pendWr <= cpuWrReq;
			pendAddr <= cpuAddr;
			pendData <= cpuWrData;
		end
		if (rdCapture) begin
			rdHold <= vramRdData;
		end
	end

	// Read word is live on the valid cycle, held afterwards
	assign cpuRdValid = rdCapture;
	assign cpuRdData = rdCapture ? vramRdData : rdHold;

	always_comb begin
		vramAddr = fastCyclePkg::shrinkBase;
		vramWrData = pendData;
		vramWrEn = 1'b0;
		unique case (slot)
			fastCyclePkg::slotCpu: begin
				if (cpuBusy) begin
					vramAddr = pendAddr;
					vramWrEn = pendWr;
				end
			end
			fastCyclePkg::slotParse: begin
				// Y table read, or an active list write
				vramAddr = parseWrEn ? parseWrAddr : parseAddr;
				vramWrData = parseWrData;
				vramWrEn = parseWrEn;
			end
			fastCyclePkg::slotActive: begin
				vramAddr = actAddr;
			end
			fastCyclePkg::slotRender: begin
				vramAddr = attrAddr;
			end
		endcase
	end

endmodule

// File: source/spriteParser.sv
// ------------------------------
// Sprite parser
// Y table scan, line match with chaining, active list writes
// ------------------------------

`timescale 1ns/1ps

module spriteParser (
	input  logic                                 clk24M,
	input  logic                                 rstN,
	input  fastCyclePkg::slotT                   slot,
	input  logic                                 lineStart,
	input  logic [fastCyclePkg::lineW-1:0]      rasterLine,
	input  logic                                 flip,
	input  logic [fastCyclePkg::vramDataW-1:0]  vramRdData,
	output logic [fastCyclePkg::vramAddrW-1:0]  parseAddr,
	output logic                                 parseWrEn,
	output logic [fastCyclePkg::vramAddrW-1:0]  parseWrAddr,
	output logic [fastCyclePkg::vramDataW-1:0]  parseWrData,
	output logic [fastCyclePkg::cntW-1:0]       listCount,
	output logic                                 parseDone
);

	logic                            scanning;
	logic                            readIssued;
	logic                            matchPend;
	logic                            prevMatch;
	logic                            bank;
	logic [fastCyclePkg::idxW-1:0]  index;
	logic [fastCyclePkg::idxW-1:0]  matchNum;
	logic [fastCyclePkg::cntW-1:0]  count;
	logic [fastCyclePkg::lineW-1:0] lineReg;
	logic                            listFull;
	logic                            inParse;
	logic                            doRead;
	logic [fastCyclePkg::lineW-1:0] sprY;
	logic [fastCyclePkg::lineW-1:0] lineDiff;
	logic [fastCyclePkg::sizeW-1:0] sprSize;
	logic                            sprChain;
	logic                            inRange;
	logic                            isMatch;

	assign listFull = (count == fastCyclePkg::cntW'(fastCyclePkg::activeCap));
	assign inParse = (slot == fastCyclePkg::slotParse) && scanning && !lineStart;

	// A pending match takes the slot unless the list is full
	assign parseWrEn = inParse && matchPend && !listFull;
	assign doRead = inParse && !parseWrEn
		&& (index < fastCyclePkg::idxW'(fastCyclePkg::numSprites));

	assign parseAddr = fastCyclePkg::yTableBase + fastCyclePkg::vramAddrW'(index);
	assign parseWrAddr = fastCyclePkg::activeBase + fastCyclePkg::vramAddrW'({bank, count});
	assign parseWrData = fastCyclePkg::vramDataW'(matchNum);

	// Y word fields, valid the cycle after the read
	assign sprY = vramRdData[fastCyclePkg::yLsb +: fastCyclePkg::lineW];
	assign sprChain = vramRdData[fastCyclePkg::chainBit];
	assign sprSize = vramRdData[fastCyclePkg::sizeW-1:0];

	// Height is size x 16 lines, wraps at 512
	assign lineDiff = lineReg - sprY;
	assign inRange = lineDiff < {sprSize[fastCyclePkg::sizeW-2:0], 4'b0000};
	// Size 32 and up covers the whole frame
	assign isMatch = sprChain ? prevMatch : (sprSize[fastCyclePkg::sizeW-1] | inRange);

	always_ff @(posedge clk24M) begin
		if (!rstN) begin
			scanning <= 1'b0;
			parseDone <= 1'b0;
			readIssued <= 1'b0;
			matchPend <= 1'b0;
			prevMatch <= 1'b0;
			index <= '0;
			count <= '0;
			listCount <= '0;
		end else if (lineStart) begin
			scanning <= 1'b1;
			parseDone <= 1'b0;
			readIssued <= 1'b0;
			matchPend <= 1'b0;
			prevMatch <= 1'b0;
			index <= '0;
			count <= '0;
			// Entries of the line that just ended
			listCount <= count;
		end else begin
			readIssued <= doRead;
			if (readIssued) begin
				matchPend <= isMatch;
				prevMatch <= isMatch;
				index <= index + 1'b1;
			end else if (inParse) begin
				// Written, or dropped on a full list
				matchPend <= 1'b0;
			end
			if (parseWrEn) begin
				count <= count + 1'b1;
			end
			if (inParse && !parseWrEn && !doRead) begin
				scanning <= 1'b0;
				parseDone <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk24M) begin
		if (lineStart) begin
			lineReg <= rasterLine;
			bank <= flip;
		end
		if (readIssued) begin
			matchNum <= index;
		end
	end

endmodule

// File: source/activeListRender.sv
// ------------------------------
// Active list render
// Reads last line's list, fetches X and shrink,
// three-stage output pipe
// ------------------------------

`timescale 1ns/1ps

module activeListRender (
	input  logic                                 clk24M,
	input  logic                                 rstN,
	input  fastCyclePkg::slotT                   slot,
	input  logic                                 lineStart,
	input  logic                                 flip,
	input  logic                                 renderEnable,
	input  logic [fastCyclePkg::cntW-1:0]       listCount,
	input  logic [fastCyclePkg::vramDataW-1:0]  vramRdData,
	output logic [fastCyclePkg::vramAddrW-1:0]  actAddr,
	output logic [fastCyclePkg::vramAddrW-1:0]  attrAddr,
	output logic                                 sprValid,
	output logic [fastCyclePkg::idxW-1:0]       sprNum,
	output logic [fastCyclePkg::lineW-1:0]      sprX,
	output logic [fastCyclePkg::hShrinkW-1:0]   sprHShrink
);

	logic                               rdBank;
	logic [fastCyclePkg::cntW-1:0]     rdCount;
	logic                               fetch;
	logic                               actIssued;
	logic                               attrIssued;
	logic                               pipeStep;
	logic                               validA;
	logic                               validB;
	logic [fastCyclePkg::idxW-1:0]     numHold;
	logic [fastCyclePkg::idxW-1:0]     numA;
	logic [fastCyclePkg::idxW-1:0]     numB;
	logic [fastCyclePkg::lineW-1:0]    xA;
	logic [fastCyclePkg::lineW-1:0]    xB;
	logic [fastCyclePkg::hShrinkW-1:0] shrinkA;
	logic [fastCyclePkg::hShrinkW-1:0] shrinkB;

	assign fetch = (slot == fastCyclePkg::slotActive) && renderEnable && !lineStart
		&& (rdCount < listCount);
	assign actAddr = fastCyclePkg::activeBase + fastCyclePkg::vramAddrW'({rdBank, rdCount});
	// Entry word arrives in the render slot and addresses the X table directly
	assign attrAddr = fastCyclePkg::xTableBase
		+ fastCyclePkg::vramAddrW'(vramRdData[fastCyclePkg::idxW-1:0]);
	assign pipeStep = (slot == fastCyclePkg::slotCpu);

	always_ff @(posedge clk24M) begin
		if (!rstN) begin
			rdCount <= '0;
			actIssued <= 1'b0;
			attrIssued <= 1'b0;
			validA <= 1'b0;
			validB <= 1'b0;
			sprValid <= 1'b0;
		end else begin
			actIssued <= fetch;
			attrIssued <= actIssued;
			if (lineStart) begin
				rdCount <= '0;
			end else if (fetch) begin
				rdCount <= rdCount + 1'b1;
			end
			// Pulse 9 cycles after the X word returns
			sprValid <= pipeStep && validB;
			if (pipeStep) begin
				validA <= attrIssued;
				validB <= validA;
			end
		end
	end

	always_ff @(posedge clk24M) begin
		// Previous line was written to the other bank
		if (lineStart) begin
			rdBank <= ~flip;
		end
		if (actIssued) begin
			numHold <= vramRdData[fastCyclePkg::idxW-1:0];
		end
		if (pipeStep) begin
			numA <= numHold;
			xA <= vramRdData[fastCyclePkg::xLsb +: fastCyclePkg::lineW];
			shrinkA <= vramRdData[fastCyclePkg::hShrinkW-1:0];
			numB <= numA;
			xB <= xA;
			shrinkB <= shrinkA;
			sprNum <= numB;
			sprX <= xB;
			sprHShrink <= shrinkB;
		end
	end

endmodule

// File: source/fastCycle.sv
// ------------------------------
// Fast cycle top
// Slot rotation over the fast VRAM for CPU and sprite blocks
// ------------------------------

`timescale 1ns/1ps

module fastCycle (
	input  logic                                 clk24M,
	input  logic                                 rstN,
	input  logic [fastCyclePkg::vramAddrW-1:0]  cpuAddr,
	input  logic [fastCyclePkg::vramDataW-1:0]  cpuWrData,
	input  logic                                 cpuWrReq,
	input  logic                                 cpuRdReq,
	output logic [fastCyclePkg::vramDataW-1:0]  cpuRdData,
	output logic                                 cpuRdValid,
	output logic                                 cpuBusy,
	input  logic                                 lineStart,
	input  logic [fastCyclePkg::lineW-1:0]      rasterLine,
	input  logic                                 flip,
	input  logic                                 renderEnable,
	output logic                                 parseDone,
	output logic                                 sprValid,
	output logic [fastCyclePkg::idxW-1:0]       sprNum,
	output logic [fastCyclePkg::lineW-1:0]      sprX,
	output logic [fastCyclePkg::hShrinkW-1:0]   sprHShrink
);

	fastCyclePkg::slotT                 slot;
	logic [fastCyclePkg::vramAddrW-1:0] vramAddr;
	logic [fastCyclePkg::vramDataW-1:0] vramWrData;
	logic                               vramWrEn;
	logic [fastCyclePkg::vramDataW-1:0] vramRdData;
	logic [fastCyclePkg::vramAddrW-1:0] parseAddr;
	logic                               parseWrEn;
	logic [fastCyclePkg::vramAddrW-1:0] parseWrAddr;
	logic [fastCyclePkg::vramDataW-1:0] parseWrData;
	logic [fastCyclePkg::cntW-1:0]      listCount;
	logic [fastCyclePkg::vramAddrW-1:0] actAddr;
	logic [fastCyclePkg::vramAddrW-1:0] attrAddr;

	slotSequencer seq0 (.clk24M, .rstN, .slot, .roundEnd());

	vramArbiter arb0 (
		.clk24M, .rstN, .slot,
		.cpuAddr, .cpuWrData, .cpuWrReq, .cpuRdReq,
		.cpuRdData, .cpuRdValid, .cpuBusy,
		.parseAddr, .parseWrEn, .parseWrAddr, .parseWrData,
		.actAddr, .attrAddr,
		.vramAddr, .vramWrData, .vramWrEn, .vramRdData
	);

	fastVram vram0 (
		.clk24M,
		.addr(vramAddr),
		.wrData(vramWrData),
		.wrEn(vramWrEn),
		.rdData(vramRdData)
	);

	spriteParser parser0 (
		.clk24M, .rstN, .slot, .lineStart, .rasterLine, .flip, .vramRdData,
		.parseAddr, .parseWrEn, .parseWrAddr, .parseWrData, .listCount, .parseDone
	);

	activeListRender render0 (
		.clk24M, .rstN, .slot, .lineStart, .flip, .renderEnable, .listCount, .vramRdData,
		.actAddr, .attrAddr, .sprValid, .sprNum, .sprX, .sprHShrink
	);

endmodule

// File: sim/tbClock.sv
// ------------------------------
// Testbench clock, 20 ns period
// ------------------------------

`timescale 1ns/1ps

module tbClock (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #10 clk = ~clk;

endmodule

// File: sim/fastCycle_sva.sv
// ------------------------------
// Fast cycle protocol checks
// Bound into the top level
// ------------------------------

`timescale 1ns/1ps

module fastCycleSva (
	input logic               clk24M,
	input logic               rstN,
	input fastCyclePkg::slotT slot,
	input logic               vramWrEn,
	input logic               cpuBusy,
	input logic               cpuRdValid,
	input logic               sprValid,
	input logic               parseDone
);

	// Failures seen by the checks below
	int failCount = 0;

	// Only the CPU and parser slots may write the VRAM
	wrSlotCheck: assert property (@(posedge clk24M) disable iff (!rstN)
		vramWrEn |-> (slot == fastCyclePkg::slotCpu || slot == fastCyclePkg::slotParse))
		else begin
			$error("VRAM write enable outside the CPU and parse slots");
			failCount++;
		end

	// Worst case waits three slots for the CPU slot
	busyFallCheck: assert property (@(posedge clk24M) disable iff (!rstN)
		$rose(cpuBusy) |-> ##[1:5] !cpuBusy)
		else begin
			$error("cpuBusy stayed high longer than 5 cycles");
			failCount++;
		end

	resetLowCheck: assert property (@(posedge clk24M)
		$rose(rstN) |-> !cpuBusy && !cpuRdValid && !sprValid && !parseDone && !vramWrEn)
		else begin
			$error("Outputs not low when reset ends");
			failCount++;
		end

	// At most one sprite per round
	sprGapCheck: assert property (@(posedge clk24M) disable iff (!rstN)
		sprValid |=> !sprValid)
		else begin
			$error("sprValid high on two consecutive cycles");
			failCount++;
		end

endmodule

bind fastCycle fastCycleSva sva0 (
	.clk24M,
	.rstN,
	.slot,
	.vramWrEn,
	.cpuBusy,
	.cpuRdValid,
	.sprValid,
	.parseDone
);

// File: sim/fastCycleTb.sv
// ------------------------------
// Fast cycle testbench
// CPU round trips, line parsing and render checks
// against a line match model
// ------------------------------

`timescale 1ns/1ps

module fastCycleTb;

	localparam int lineCycles = 600;
	localparam int numLines = 9;
	localparam int numCpuOps = 432;
	localparam int opCycles = 8;
	localparam int timeoutCycles = 16 + numLines * lineCycles + numCpuOps * opCycles + 1000;

	logic        clk24M;
	logic        rstN;
	logic [10:0] cpuAddr;
	logic [15:0] cpuWrData;
	logic        cpuWrReq;
	logic        cpuRdReq;
	logic [15:0] cpuRdData;
	logic        cpuRdValid;
	logic        cpuBusy;
	logic        lineStart;
	logic [8:0]  rasterLine;
	logic        flip;
	logic        renderEnable;
	logic        parseDone;
	logic        sprValid;
	logic [6:0]  sprNum;
	logic [8:0]  sprX;
	logic [3:0]  sprHShrink;

	// Model copies of the tables and of CPU scratch writes
	logic [15:0] yTab [0:95];
	logic [15:0] xTab [0:95];
	logic [15:0] shadow [0:2047];
	int expQ[$];
	int numQ[$];
	int xQ[$];
	int shQ[$];
	int errorCount = 0;
	int testsOk = 0;
	int testsBad = 0;
	int cycleCount = 0;
	bit trafficStop;

	tbClock clkGen0 (.clk(clk24M));

	fastCycle dut0 (.*);

	always @(negedge clk24M) begin
		if (sprValid === 1'b1) begin
			numQ.push_back(sprNum);
			xQ.push_back(sprX);
			shQ.push_back(sprHShrink);
		end
	end

	function automatic logic [15:0] yWord(input logic [8:0] y, input logic chain,
		input logic [5:0] size);
		return {y, chain, size};
	endfunction

	// Line match with chaining up to the active list size
	function automatic void buildExpected(input int line);
		int i;
		int diff;
		bit m;
		bit prevM;
		expQ.delete();
		prevM = 1'b0;
		for (i = 0; i < 96; i++) begin
			diff = (line - int'(yTab[i][15:7])) & 511;
			if (yTab[i][6]) begin
				m = prevM;
			end else begin
				m = (yTab[i][5:0] >= 32) || (diff < int'(yTab[i][5:0]) * 16);
			end
			prevM = m;
			if (m && expQ.size() < 48) begin
				expQ.push_back(i);
			end
		end
	endfunction

	task automatic cpuAccess(input logic wr, input logic [10:0] addr, input logic [15:0] data,
		output logic [15:0] rd);
		int lat;
		@(posedge clk24M);
		#2;
		cpuAddr = addr;
		cpuWrData = data;
		cpuWrReq = wr;
		cpuRdReq = !wr;
		@(posedge clk24M);
		#2;
		cpuWrReq = 1'b0;
		cpuRdReq = 1'b0;
		lat = 0;
		do begin
			@(negedge clk24M);
			lat++;
		end while (cpuBusy !== 1'b0 && lat < opCycles);
		assert (lat >= 2 && lat <= 5) else begin
			$display("ERROR at %0t cpuBusy latency got %0d expected 2 to 5", $time, lat);
			errorCount++;
		end
		if (!wr) begin
			assert (cpuRdValid === 1'b1) else begin
				$display("ERROR at %0t no cpuRdValid pulse when the read ended", $time);
				errorCount++;
			end
		end
		rd = cpuRdData;
	endtask

	task automatic writeTables(input bit withX);
		int i;
		logic [15:0] rd;
		for (i = 0; i < 96; i++) begin
			cpuAccess(1'b1, fastCyclePkg::yTableBase + 11'(i), yTab[i], rd);
			if (withX) begin
				cpuAccess(1'b1, fastCyclePkg::xTableBase + 11'(i), xTab[i], rd);
			end
		end
	endtask

	task automatic checkRender();
		int k;
		assert (numQ.size() == expQ.size()) else begin
			$display("ERROR at %0t sprite count got %0d expected %0d", $time, numQ.size(),
				expQ.size());
			errorCount++;
		end
		for (k = 0; k < numQ.size() && k < expQ.size(); k++) begin
			assert (numQ[k] == expQ[k]) else begin
				$display("ERROR at %0t sprNum got %0d expected %0d", $time, numQ[k], expQ[k]);
				errorCount++;
			end
			assert (xQ[k] == int'(xTab[expQ[k]][15:7])) else begin
				$display("ERROR at %0t sprX got %0d expected %0d", $time, xQ[k],
					xTab[expQ[k]][15:7]);
				errorCount++;
			end
			assert (shQ[k] == int'(xTab[expQ[k]][3:0])) else begin
				$display("ERROR at %0t sprHShrink got %0d expected %0d", $time, shQ[k],
					xTab[expQ[k]][3:0]);
				errorCount++;
			end
		end
	endtask

	// Parses one line and with render on checks the previous line's list
	task automatic runLine(input int line, input bit render);
		int n;
		@(posedge clk24M);
		#2;
		numQ.delete();
		xQ.delete();
		shQ.delete();
		lineStart = 1'b1;
		rasterLine = 9'(line);
		flip = !flip;
		renderEnable = render;
		@(posedge clk24M);
		#2;
		lineStart = 1'b0;
		n = 0;
		while (parseDone !== 1'b1 && n < lineCycles) begin
			@(negedge clk24M);
			n++;
		end
		assert (parseDone === 1'b1) else begin
			$display("ERROR at %0t parseDone never rose for line %0d", $time, line);
			errorCount++;
		end
		repeat (16) @(negedge clk24M);
		if (render) begin
			checkRender();
		end
		buildExpected(line);
	endtask

	task automatic finishTest(input string name, input int errStart);
		if (errorCount == errStart) begin
			testsOk++;
			$display("Test %s ok", name);
		end else begin
			testsBad++;
			$display("Test %s had %0d errors", name, errorCount - errStart);
		end
	endtask

	initial begin
		int i;
		int errStart;
		logic [10:0] a;
		logic [15:0] d;
		logic [15:0] rd;
		logic [10:0] addrQ[$];
		void'($urandom(59));
		rstN = 1'b0;
		cpuAddr = '0;
		cpuWrData = '0;
		cpuWrReq = 1'b0;
		cpuRdReq = 1'b0;
		lineStart = 1'b0;
		rasterLine = '0;
		flip = 1'b0;
		renderEnable = 1'b0;
		repeat (16) @(posedge clk24M);
		#2;
		rstN = 1'b1;

		errStart = errorCount;
		for (i = 0; i < 24; i++) begin
			a = 11'($urandom);
			d = 16'($urandom);
			shadow[a] = d;
			addrQ.push_back(a);
			cpuAccess(1'b1, a, d, rd);
		end
		foreach (addrQ[k]) begin
			cpuAccess(1'b0, addrQ[k], 16'h0000, rd);
			assert (rd == shadow[addrQ[k]]) else begin
				$display("ERROR at %0t cpuRdData got %h expected %h", $time, rd,
					shadow[addrQ[k]]);
				errorCount++;
			end
		end
		finishTest("cpu round trip", errStart);

		// Heights up to 240 lines with one in eight chained
		errStart = errorCount;
		for (i = 0; i < 96; i++) begin
			yTab[i] = yWord(9'($urandom), ($urandom % 8) == 0, 6'($urandom % 16));
			xTab[i] = 16'($urandom);
		end
		writeTables(1'b1);
		runLine(120, 1'b0);
		runLine(121, 1'b1);
		finishTest("y matching", errStart);

		errStart = errorCount;
		trafficStop = 1'b0;
		fork
			begin
				runLine(120, 1'b0);
				runLine(121, 1'b1);
				trafficStop = 1'b1;
			end
			while (!trafficStop) begin
				// Unused low region keeps the tables and lists intact
				a = 11'($urandom % 512);
				d = 16'($urandom);
				cpuAccess(1'b1, a, d, rd);
				cpuAccess(1'b0, a, 16'h0000, rd);
				assert (rd == d) else begin
					$display("ERROR at %0t cpuRdData got %h expected %h", $time, rd, d);
					errorCount++;
				end
			end
		join
		finishTest("concurrent cpu traffic", errStart);

		errStart = errorCount;
		for (i = 0; i < 96; i++) begin
			yTab[i] = yWord(9'd300, 1'b0, 6'd1);
		end
		yTab[0] = yWord(9'd400, 1'b0, 6'd40);
		yTab[10] = yWord(9'd90, 1'b0, 6'd2);
		yTab[20] = yWord(9'd300, 1'b0, 6'd1);
		yTab[40] = yWord(9'd240, 1'b0, 6'd1);
		for (i = 1; i <= 4; i++) begin
			yTab[10 + i] = yWord(9'd300, 1'b1, 6'd1);
			// Own Y would match line 100
			yTab[20 + i] = yWord(9'd100, 1'b1, 6'd4);
		end
		for (i = 41; i <= 43; i++) begin
			yTab[i] = yWord(9'd0, 1'b1, 6'd0);
		end
		writeTables(1'b0);
		runLine(100, 1'b0);
		runLine(250, 1'b1);
		runLine(251, 1'b1);
		finishTest("chaining and large sprites", errStart);

		// 60 large sprites and the rest of size 0
		errStart = errorCount;
		for (i = 0; i < 96; i++) begin
			if (i % 8 < 5) begin
				yTab[i] = yWord(9'($urandom), 1'b0, 6'(32 + $urandom % 32));
			end else begin
				yTab[i] = yWord(9'($urandom), 1'b0, 6'd0);
			end
		end
		writeTables(1'b0);
		runLine(200, 1'b0);
		runLine(201, 1'b1);
		finishTest("full list", errStart);

		// Protocol check failures from the bound checker
		errorCount = errorCount + dut0.sva0.failCount;
		$display("Summary %0d tests ok, %0d with errors, %0d errors in total", testsOk,
			testsBad, errorCount);
		if (errorCount == 0 && testsBad == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		while (cycleCount < timeoutCycles) begin
			@(posedge clk24M);
			cycleCount++;
		end
		$display("Run stopped after %0d cycles without finishing", cycleCount);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: fastCycle.f
source/fastCyclePkg.sv
source/fastVram.sv
source/slotSequencer.sv
source/vramArbiter.sv
source/spriteParser.sv
source/activeListRender.sv
source/fastCycle.sv
sim/tbClock.sv
sim/fastCycle_sva.sv
sim/fastCycleTb.sv
